// ==== rtl/alioth_params.svh ====
`ifndef ALIOTH_PARAMS_SVH
`define ALIOTH_PARAMS_SVH

// instruction memory size as a byte address width
`define ITCM_ADDR_WIDTH 8

// first fetch after reset
`define RESET_PC 32'h0000_0000

// the program parks in a loop through this address when it is done
`define PC_WRITE_TOHOST 32'h0000_0040

// separate arrivals at tohost that end a test
`define TOHOST_HITS 8

`endif

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000; // sub in the op group

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5  // lui takes operand b straight through
    } alu_op_e;

    // fixed fields of a 32-bit instruction word in R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

// ==== rtl/core_pkg.sv ====
package core_pkg;

    // fetch to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    // decode to execute with operands already read
    typedef struct packed {
        logic [31:0]      pc;
        logic [31:0]      rs1_val;
        logic [31:0]      rs2_val;
        logic [31:0]      imm;
        logic [4:0]       rd;
        isa_pkg::alu_op_e alu_op;
        logic             reg_we;
        logic             use_imm;   // operand b is the immediate
        logic             is_branch;
        logic             branch_ne; // bne rather than beq
        logic             is_jal;
    } decode_pkt_t;

    // execute back to the regfile
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0; // squash the younger instruction
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== rtl/ifu.sv ====
`timescale 1ns/1ns

`include "alioth_params.svh"

module ifu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    input  logic                        load_en,
    input  logic [`ITCM_ADDR_WIDTH-1:0] load_addr,
    input  logic [31:0]                 load_data,
    input  logic                        redirect,
    input  logic [31:0]                 redirect_pc,
    output core_pkg::fetch_pkt_t        fetch,
    output logic                        fetch_valid,
    output logic [31:0]                 pc
);

    localparam int ITCM_DEPTH = 1 << (`ITCM_ADDR_WIDTH - 2); // words

    logic [31:0] itcm [0:ITCM_DEPTH-1];
    logic [31:0] instr_q; // word read for pc_q
    logic [31:0] pc_q;    // pc that was issued last cycle

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else if (run) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 32'd4;
            end
            // word coming back now is on the wrong path
            fetch_valid <= !redirect;
        end
    end

    // instruction memory with its load port open even in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            itcm[load_addr[`ITCM_ADDR_WIDTH-1:2]] <= load_data;
        end
        if (run) begin
            instr_q <= itcm[pc[`ITCM_ADDR_WIDTH-1:2]];
            pc_q    <= pc;
        end
    end

    assign fetch.pc    = pc_q;
    assign fetch.instr = instr_q;

endmodule

// ==== rtl/idu.sv ====
`timescale 1ns/1ns

module idu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::fetch_pkt_t  fetch,
    input  logic                  fetch_valid,
    input  core_pkg::wb_t         wb,
    output core_pkg::decode_pkt_t dec,
    output logic                  dec_valid,
    output logic [31:0]           gp
);

    import isa_pkg::*;

    instr_fields_t ins;
    logic [31:0]   regs [0:31];
    logic [31:0]   imm_i;
    logic [31:0]   imm_u;
    logic [31:0]   imm_b;
    logic [31:0]   imm_j;
    logic          legal;

    assign ins = fetch.instr;

    assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
    assign imm_u = {fetch.instr[31:12], 12'b0};
    assign imm_b = {{20{fetch.instr[31]}}, fetch.instr[7], fetch.instr[30:25],
                    fetch.instr[11:8], 1'b0};
    assign imm_j = {{12{fetch.instr[31]}}, fetch.instr[19:12], fetch.instr[20],
                    fetch.instr[30:21], 1'b0};

    // regfile where x0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // read ports where a same-cycle writeback wins
    always_comb begin
        if (ins.rs1 == 5'd0) begin
            dec.rs1_val = '0;
        end else if (wb.en && wb.rd == ins.rs1) begin
            dec.rs1_val = wb.data;
        end else begin
            dec.rs1_val = regs[ins.rs1];
        end
        if (ins.rs2 == 5'd0) begin
            dec.rs2_val = '0;
        end else if (wb.en && wb.rd == ins.rs2) begin
            dec.rs2_val = wb.data;
        end else begin
            dec.rs2_val = regs[ins.rs2];
        end
    end

    always_comb begin
        dec.pc        = fetch.pc;
        dec.rd        = ins.rd;
        dec.imm       = imm_i;
        dec.alu_op    = ALU_ADD;
        dec.reg_we    = 1'b0;
        dec.use_imm   = 1'b0;
        dec.is_branch = 1'b0;
        dec.branch_ne = 1'b0;
        dec.is_jal    = 1'b0;
        legal         = 1'b0;
        case (ins.opcode)
            OPC_LUI: begin
                legal       = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
                legal       = 1'b1;
                case (ins.funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_AND:     dec.alu_op = ALU_AND;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    default:    legal = 1'b0; // shifts and compares not here
                endcase
            end
            OPC_OP: begin
                dec.reg_we = 1'b1;
                legal      = (ins.funct7 == F7_BASE);
                case (ins.funct3)
                    F3_ADD_SUB: begin
                        legal      = (ins.funct7 == F7_BASE) || (ins.funct7 == F7_SUB);
                        dec.alu_op = (ins.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    end
                    F3_AND:  dec.alu_op = ALU_AND;
                    F3_OR:   dec.alu_op = ALU_OR;
                    F3_XOR:  dec.alu_op = ALU_XOR;
                    default: legal = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = (ins.funct3 == F3_BNE);
                legal         = (ins.funct3 == F3_BEQ) || (ins.funct3 == F3_BNE);
            end
            OPC_JAL: begin
                legal      = 1'b1;
                dec.imm    = imm_j;
                dec.reg_we = 1'b1; // link
                dec.is_jal = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign dec_valid = fetch_valid && legal; // anything else is a bubble
    assign gp        = regs[3];

endmodule

// ==== rtl/exu.sv ====
`timescale 1ns/1ns

module exu (
    input  core_pkg::decode_pkt_t dec,
    input  logic                  dec_valid,
    input  logic                  run,
    output core_pkg::wb_t         wb,
    output logic                  redirect,
    output logic [31:0]           redirect_pc
);

    import isa_pkg::*;

    logic        live; // instruction retires this cycle
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        taken;

    assign live = dec_valid && run;
    assign op_b = dec.use_imm ? dec.imm : dec.rs2_val;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = dec.rs1_val + op_b;
            ALU_SUB:    alu_res = dec.rs1_val - op_b;
            ALU_AND:    alu_res = dec.rs1_val & op_b;
            ALU_OR:     alu_res = dec.rs1_val | op_b;
            ALU_XOR:    alu_res = dec.rs1_val ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // equality decides beq and branch_ne flips it for bne
    assign taken = dec.is_jal ||
                   (dec.is_branch && ((dec.rs1_val == dec.rs2_val) ^ dec.branch_ne));

    always_comb begin
        wb          = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        if (live) begin
            wb.en       = dec.reg_we;
            wb.rd       = dec.rd;
            wb.data     = dec.is_jal ? dec.pc + 32'd4 : alu_res;
            redirect    = taken;
            redirect_pc = dec.pc + dec.imm; // pc relative for both
        end
    end

endmodule

// ==== rtl/test_monitor.sv ====
`timescale 1ns/1ns

`include "alioth_params.svh"

module test_monitor (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic [31:0] pc,
    input  logic [31:0] gp,
    output logic        led_pass,
    output logic        led_fail
);

    localparam int CNT_W = $clog2(`TOHOST_HITS + 1);

    logic [31:0]      prev_pc;
    logic [CNT_W-1:0] hit_cnt;
    logic             done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_pc  <= `RESET_PC;
            hit_cnt  <= '0;
            done     <= 1'b0;
            led_pass <= 1'b0;
            led_fail <= 1'b0;
        end else if (run) begin
            prev_pc <= pc;
            // one arrival per visit rather than per cycle spent there
            if (!done && pc == `PC_WRITE_TOHOST && pc != prev_pc) begin
                hit_cnt <= hit_cnt + CNT_W'(1);
            end
            if (!done && hit_cnt == CNT_W'(`TOHOST_HITS)) begin
                done     <= 1'b1; // verdict frozen until reset
                led_pass <= (gp == 32'd1);
                led_fail <= (gp != 32'd1);
            end
        end
    end

endmodule

// ==== rtl/fpga_top.sv ====
`timescale 1ns/1ns

`include "alioth_params.svh"

module fpga_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    input  logic                        load_en,
    input  logic [`ITCM_ADDR_WIDTH-1:0] load_addr,
    input  logic [31:0]                 load_data,
    output logic                        led_pass,
    output logic                        led_fail
);

    import core_pkg::*;

    fetch_pkt_t  if_pkt;
    logic        if_valid;
    fetch_pkt_t  id_pkt;   // after u_fd
    logic        id_valid;
    decode_pkt_t dec_pkt;
    logic        dec_valid;
    decode_pkt_t ex_pkt;   // after u_de
    logic        ex_valid;
    wb_t         wb;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] fetch_pc;
    logic [31:0] gp;

    ifu u_ifu (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch       (if_pkt),
        .fetch_valid (if_valid),
        .pc          (fetch_pc)
    );

    pipe_reg #(.payload_t(fetch_pkt_t)) u_fd (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (!run),
        .flush     (redirect),
        .in_valid  (if_valid),
        .in_data   (if_pkt),
        .out_valid (id_valid),
        .out_data  (id_pkt)
    );

    idu u_idu (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (id_pkt),
        .fetch_valid (id_valid),
        .wb          (wb),
        .dec         (dec_pkt),
        .dec_valid   (dec_valid),
        .gp          (gp)
    );

    pipe_reg #(.payload_t(decode_pkt_t)) u_de (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (!run),
        .flush     (redirect),
        .in_valid  (dec_valid),
        .in_data   (dec_pkt),
        .out_valid (ex_valid),
        .out_data  (ex_pkt)
    );

    exu u_exu (
        .dec         (ex_pkt),
        .dec_valid   (ex_valid),
        .run         (run),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    test_monitor u_monitor (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .pc       (fetch_pc),
        .gp       (gp),
        .led_pass (led_pass),
        .led_fail (led_fail)
    );

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 16
) (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset at time zero and again on every rst_req pulse
    initial begin
        rst_n <= 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n <= 1'b1; // released away from the active edge
            @(posedge rst_req);
            @(negedge clk);
            rst_n <= 1'b0;
        end
    end

endmodule

// ==== verif/tb_fpga_top.sv ====
`timescale 1ns/1ns

`include "alioth_params.svh"

module tb_fpga_top;

    localparam int          AW      = `ITCM_ADDR_WIDTH;
    localparam int          WORDS   = 1 << (AW - 2);
    localparam logic [31:0] LOOP_PC = 32'h0000_003c; // nop here and the jal back sits at tohost

    logic          clk;
    logic          rst_n;
    logic          rst_req;
    logic          run;
    logic          load_en;
    logic [AW-1:0] load_addr;
    logic [31:0]   load_data;
    logic          led_pass;
    logic          led_fail;

    logic [31:0] prog [0:WORDS-1]; // image written by load_program
    int          wr_ptr;           // next word index
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    tb_clkgen u_clkgen (
        .rst_req (rst_req),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    fpga_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .led_pass  (led_pass),
        .led_fail  (led_fail)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[wr_ptr] = word;
        wr_ptr++;
    endtask

    task automatic emit_jal(input logic [31:0] target);
        logic [31:0] off;
        off = target - (32'(wr_ptr) << 2);
        emit(jal_word(5'd0, off[20:0]));
    endtask

    task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [31:0] target);
        logic [31:0] off;
        off = target - (32'(wr_ptr) << 2);
        emit(branch_word(f3, rs1, rs2, off[12:0]));
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(lui_word(rd, hi[31:12]));
        emit(addi_word(rd, rd, value[11:0]));
    endtask

    task automatic emit_alu_check(input logic [6:0] f7, input logic [2:0] f3,
                                  input logic [31:0] expected);
        emit(rtype_word(f7, f3, 5'd4, 5'd1, 5'd2)); // x4 = x1 op x2
        emit_li(5'd5, expected);
        emit_branch(3'b001, 5'd4, 5'd5, LOOP_PC);   // bne to the loop leaves x3 at 0
    endtask

    task automatic new_program();
        for (int i = 0; i < WORDS; i++) begin
            prog[i] = addi_word(5'd0, 5'd0, 12'(i * 4)); // nop whose imm follows the address
        end
        wr_ptr = 16; // tohost
        emit_jal(LOOP_PC);
        wr_ptr = 0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR: time %0t, %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_leds(input logic exp_pass, input logic exp_fail);
        check_value("led_pass", 32'(exp_pass), 32'(led_pass));
        check_value("led_fail", 32'(exp_fail), 32'(led_fail));
    endtask

    task automatic wait_rst(input logic level);
        int n;
        n = 0;
        while (rst_n !== level && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== level) begin
            errors++;
            $display("reset did not reach level %0b within 100 cycles", level);
        end
    endtask

    task automatic wait_for_led(input int max_cycles);
        int n;
        n = 0;
        while (!(led_pass || led_fail) && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!(led_pass || led_fail)) begin
            errors++;
            $display("timeout: neither LED lit within %0d cycles", max_cycles);
        end
    endtask

    // write prog with the core stopped then reset and let it run
    task automatic load_program(input int idle_cycles);
        @(negedge clk);
        run = 1'b0;
        wait_rst(1'b1);
        for (int i = 0; i < WORDS; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = AW'(i * 4);
            load_data = prog[i];
        end
        @(negedge clk);
        load_en = 1'b0;
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        wait_rst(1'b0);
        wait_rst(1'b1);
        for (int i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            check_leds(1'b0, 1'b0); // nothing may light while held
        end
        run = 1'b1;
    endtask

    task automatic test_idle_then_pass();
        new_program();
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit_jal(LOOP_PC);
        load_program(20);
        wait_for_led(400);
        check_leds(1'b1, 1'b0);
    endtask

    task automatic test_fail_verdict();
        new_program();
        emit(addi_word(5'd3, 5'd0, 12'd5));
        emit_jal(LOOP_PC);
        load_program(2);
        wait_for_led(400);
        check_leds(1'b0, 1'b1);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_leds(1'b0, 1'b1); // verdict is frozen
        end
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int round = 0; round < 3; round++) begin
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state;
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state;
            new_program();
            emit_jal(32'h80); // code lives above the tohost loop
            wr_ptr = 32;
            emit_li(5'd1, a);
            emit_li(5'd2, b);
            emit_alu_check(7'h00, 3'b000, a + b);
            emit_alu_check(7'h20, 3'b000, a - b);
            emit_alu_check(7'h00, 3'b100, a ^ b);
            emit_alu_check(7'h00, 3'b110, a | b);
            emit_alu_check(7'h00, 3'b111, a & b);
            emit(addi_word(5'd3, 5'd0, 12'd1));
            emit_jal(LOOP_PC);
            load_program(2);
            wait_for_led(400);
            check_leds(1'b1, 1'b0);
        end
    endtask

    task automatic test_flush();
        new_program();
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit_branch(3'b000, 5'd0, 5'd0, 32'h14); // beq always taken
        emit(addi_word(5'd3, 5'd0, 12'd0));
        emit(addi_word(5'd3, 5'd0, 12'd0));
        emit(addi_word(5'd3, 5'd0, 12'd0)); // still in the memory read at redirect
        emit_jal(32'h24);
        emit(addi_word(5'd3, 5'd0, 12'd0));
        emit(addi_word(5'd3, 5'd0, 12'd0));
        emit(addi_word(5'd3, 5'd0, 12'd0));
        emit_jal(LOOP_PC);
        load_program(2);
        wait_for_led(400);
        check_leds(1'b1, 1'b0);
    endtask

    task automatic test_bypass();
        int sum;
        sum = 8 * 9 / 2; // 1 + 2 + ... + 8
        new_program();
        emit(addi_word(5'd2, 5'd0, 12'(sum)));
        emit(addi_word(5'd1, 5'd0, 12'd1));
        for (int i = 2; i <= 8; i++) begin
            emit(addi_word(5'd1, 5'd1, 12'(i))); // each reads the one before
        end
        emit_branch(3'b000, 5'd1, 5'd2, (32'(wr_ptr) << 2) + 32'd8);
        emit_jal(LOOP_PC);
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit_jal(LOOP_PC);
        load_program(2);
        wait_for_led(400);
        check_leds(1'b1, 1'b0);
    endtask

    initial begin
        rst_req   = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lcg_state = 32'd27;
        errors    = 0;
        checks    = 0;
        wr_ptr    = 0;
        test_idle_then_pass();
        test_fail_verdict();
        test_alu_ops();
        test_flush();
        test_bypass();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/pipe_reg.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/test_monitor.sv
rtl/fpga_top.sv
verif/tb_clkgen.sv
verif/tb_fpga_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module tb_fpga_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log"; then
    exit 1
fi
exit 0
